//--- hw/lcd_cfg.svh
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Delays in i_clock cycles
//////////////////////////////////////////////////////////////////////
`define LCD_RESET_HOLD     30       // Also fine on hardware
`define LCD_RESET_WAIT     200      // 1000000 on hardware
`define LCD_STANDBY_WAIT   200      // 1000000 on hardware
`define LCD_SLEEP_WAIT     300      // One second of clocks on hardware
`define LCD_RETRY_WAIT     100      // One second of clocks on hardware

`define LCD_SCLK_HALF      2        // Cycles per serial clock half period
`define LCD_CLOCK_MHZ      25       // Panel clock rate written to REG_CLOCK

//////////////////////////////////////////////////////////////////////
// Frame geometry
//////////////////////////////////////////////////////////////////////
`define LCD_LINES          16       // 1280 on the real panel
`define LCD_WORDS_DATA     40       // Valid words per line
`define LCD_WORDS_LINE     44       // Clocks per line
`define LCD_BACK_PORCH     24       // Idle clocks before next update
`define LCD_UPDATE_LEN     48       // Update pulse length
`define LCD_BAND_LO        4        // 320 on the real panel
`define LCD_BAND_HI        12       // 960 on the real panel

// Register map
`define REG_MODE           7'h01
`define REG_ROW_BASE       7'h06    // Row address MSB then LSB
`define REG_CMD            7'h08
`define REG_CLOCK          7'h09
`define REG_START_BASE     7'h0A    // Start row MSB then LSB
`define REG_CONFIG         7'h78

// Register values
`define CMD_SET_START      8'h30    // Start pointer from row registers
`define CMD_SET_CURRENT    8'h40    // Current pointer from row registers
`define MODE_SLEEP         8'd0
`define MODE_STANDBY       8'd1
`define MODE_NORMAL        8'd2
`define CONFIG_ID          8'h20    // Only released panel revision

`endif

//--- hw/lcd_pkg.sv
package lcd_pkg;

	typedef logic [6:0]  lcd_addr_t;   // Panel register address
	typedef logic [7:0]  lcd_byte_t;   // Panel register value
	typedef logic [31:0] lcd_word_t;   // One pixel data word
	typedef logic [31:0] lcd_count_t;  // Delay and frame counters

	// Sequencer states, listed in visiting order
	typedef enum logic [4:0] {
		ST_RESET_HOLD,     // Panel held in reset, no clock
		ST_RESET_WAIT,     // Reset released, panel boots
		ST_RD_CONFIG,
		ST_WR_ROW_MSB,
		ST_WR_ROW_LSB,
		ST_CMD_START,
		ST_CMD_CURRENT,
		ST_RD_START_MSB,
		ST_RD_START_LSB,
		ST_WR_CLOCK,
		ST_RD_CLOCK,
		ST_WR_STANDBY,
		ST_RETRY_WAIT,     // Back off after a failed check
		ST_STANDBY_WAIT,
		ST_WR_NORMAL,
		ST_NORMAL,         // Frames streaming
		ST_WR_SLEEP,
		ST_SLEEP_WAIT,
		ST_SHUTDOWN        // Clock and reset removed
	} power_state_t;

endpackage

//--- hw/lcd_serial_tcvr.sv
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module lcd_serial_tcvr
(
	input  logic               i_clock,
	input  logic               i_rst,
	input  logic               i_start,   // One cycle request while idle
	input  logic               i_read,    // Read flag, first bit on the wire
	input  lcd_pkg::lcd_addr_t i_addr,
	input  lcd_pkg::lcd_byte_t i_wdata,
	input  logic               i_miso,
	output logic               o_sclk,
	output logic               o_mosi,
	output logic               o_sen,
	output logic               o_busy,
	output logic               o_done,
	output lcd_pkg::lcd_byte_t o_rdata
);

	import lcd_pkg::*;

	localparam int DIV_W = $clog2(`LCD_SCLK_HALF + 1);

	logic [DIV_W-1:0] r_div;       // Cycles into current half period
	logic [4:0]       r_half;      // Half period index, 32 per frame
	logic [15:0]      r_shift;     // Outgoing frame, MSB on the wire
	lcd_byte_t        r_rdata;     // Incoming bits, last 8 are data
	logic             r_sclk;
	logic             r_sen;
	logic             r_busy;
	logic             r_done;
	logic             w_half_end;  // Last cycle of a half period

	assign w_half_end = (r_div == DIV_W'(`LCD_SCLK_HALF - 1));

	//////////////////////////////////////////////////////////////////////
	// Link control
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clock)
	begin
		if (i_rst)
		begin
			r_div  <= '0;
			r_half <= '0;
			r_sclk <= 1'b0;
			r_sen  <= 1'b0;
			r_busy <= 1'b0;
			r_done <= 1'b0;
		end
		else
		begin
			r_done <= 1'b0;                    // Pulse only
			if (!r_busy)
			begin
				if (i_start)
				begin
					r_busy <= 1'b1;
					r_sen  <= 1'b1;            // Frame opens with sclk low
					r_div  <= '0;
					r_half <= '0;
				end
			end
			else if (r_sen)
			begin
				if (w_half_end)
				begin
					r_div  <= '0;
					r_sclk <= ~r_sclk;
					r_half <= r_half + 5'd1;
					if (r_half == 5'd31)
						r_sen <= 1'b0;         // Final falling edge closes frame
				end
				else
					r_div <= r_div + 1'b1;
			end
			else
			begin
				r_busy <= 1'b0;                // Tail cycle, hand back
				r_done <= 1'b1;
			end
		end
	end

	// Shift paths
	always_ff @(posedge i_clock)
	begin
		if (!r_busy && i_start)
			r_shift <= {i_read, i_addr, i_wdata};
		else if (r_sen && w_half_end)
		begin
			if (r_sclk)
				r_shift <= {r_shift[14:0], 1'b0};  // Next bit as sclk falls
			else
				r_rdata <= {r_rdata[6:0], i_miso}; // Sample as sclk rises
		end
	end

	assign o_sclk  = r_sclk;
	assign o_mosi  = r_sen & r_shift[15];      // Quiet between frames
	assign o_sen   = r_sen;
	assign o_busy  = r_busy;
	assign o_done  = r_done;
	assign o_rdata = r_rdata;

endmodule

//--- hw/lcd_power_seq.sv
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module lcd_power_seq
(
	input  logic               i_clock,
	input  logic               i_rst,
	input  logic               i_shutdown_n,  // Low requests sleep
	input  logic               i_busy,
	input  logic               i_done,
	input  lcd_pkg::lcd_byte_t i_rdata,
	output logic               o_tx_start,
	output logic               o_tx_read,
	output lcd_pkg::lcd_addr_t o_tx_addr,
	output lcd_pkg::lcd_byte_t o_tx_wdata,
	output logic               o_nreset,
	output logic               o_clock_en,
	output logic               o_run,
	output logic               o_ready,
	output logic               o_fail
);

	import lcd_pkg::*;

	power_state_t r_state;
	lcd_count_t   r_count;      // Cycles spent in a delay state
	logic         r_issued;     // Transaction of this state in flight
	logic         r_tx_start;
	logic         r_tx_read;
	lcd_addr_t    r_tx_addr;
	lcd_byte_t    r_tx_wdata;
	logic         r_nreset;
	logic         r_clock_en;
	logic         r_run;
	logic         r_ready;
	logic         r_fail;
	logic         w_tx_state;   // State owns a register transaction
	logic [15:0]  w_tx;         // Read flag, address, write data
	lcd_count_t   w_delay_len;  // Zero outside delay states
	logic         w_rd_ok;      // Read back value passes its check
	logic         w_delay_end;
	logic         w_issue;
	logic         w_step;
	logic         w_retry;

	//////////////////////////////////////////////////////////////////////
	// Per state transaction, delay and read check
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		w_tx_state  = 1'b1;
		w_tx        = '0;
		w_delay_len = '0;
		w_rd_ok     = 1'b1;
		case (r_state)
			ST_RD_CONFIG:    w_tx = {1'b1, `REG_CONFIG, 8'h00};
			ST_WR_ROW_MSB:   w_tx = {1'b0, `REG_ROW_BASE, 8'h00};
			ST_WR_ROW_LSB:   w_tx = {1'b0, `REG_ROW_BASE + 7'd1, 8'h00};
			ST_CMD_START:    w_tx = {1'b0, `REG_CMD, `CMD_SET_START};
			ST_CMD_CURRENT:  w_tx = {1'b0, `REG_CMD, `CMD_SET_CURRENT};
			ST_RD_START_MSB: w_tx = {1'b1, `REG_START_BASE, 8'h00};
			ST_RD_START_LSB: w_tx = {1'b1, `REG_START_BASE + 7'd1, 8'h00};
			ST_WR_CLOCK:     w_tx = {1'b0, `REG_CLOCK, lcd_byte_t'(`LCD_CLOCK_MHZ)};
			ST_RD_CLOCK:     w_tx = {1'b1, `REG_CLOCK, 8'h00};
			ST_WR_STANDBY:   w_tx = {1'b0, `REG_MODE, `MODE_STANDBY};
			ST_WR_NORMAL:    w_tx = {1'b0, `REG_MODE, `MODE_NORMAL};
			ST_WR_SLEEP:     w_tx = {1'b0, `REG_MODE, `MODE_SLEEP};
			default:         w_tx_state = 1'b0;
		endcase
		case (r_state)
			ST_RESET_HOLD:   w_delay_len = lcd_count_t'(`LCD_RESET_HOLD);
			ST_RESET_WAIT:   w_delay_len = lcd_count_t'(`LCD_RESET_WAIT);
			ST_RETRY_WAIT:   w_delay_len = lcd_count_t'(`LCD_RETRY_WAIT);
			ST_STANDBY_WAIT: w_delay_len = lcd_count_t'(`LCD_STANDBY_WAIT);
			ST_SLEEP_WAIT:   w_delay_len = lcd_count_t'(`LCD_SLEEP_WAIT);
			ST_RD_CONFIG:    w_rd_ok = (i_rdata == `CONFIG_ID);
			ST_RD_START_MSB: w_rd_ok = (i_rdata[2:0] == 3'd0);   // Row bits only
			ST_RD_START_LSB: w_rd_ok = (i_rdata == 8'h00);
			ST_RD_CLOCK:     w_rd_ok = (i_rdata == lcd_byte_t'(`LCD_CLOCK_MHZ));
			default:         ;
		endcase
	end

	assign w_delay_end = (r_count == w_delay_len - lcd_count_t'(1));
	assign w_issue     = w_tx_state && !r_issued && !i_busy;
	assign w_step      = i_done && w_rd_ok;
	assign w_retry     = i_done && !w_rd_ok;

	//////////////////////////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clock)
	begin
		if (i_rst)
		begin
			r_state    <= ST_RESET_HOLD;
			r_count    <= '0;
			r_issued   <= 1'b0;
			r_tx_start <= 1'b0;
			r_nreset   <= 1'b0;
			r_clock_en <= 1'b0;
			r_run      <= 1'b0;
			r_ready    <= 1'b0;
			r_fail     <= 1'b0;
		end
		else
		begin
			r_tx_start <= w_issue;                 // Single cycle start
			if (w_issue)
				r_issued <= 1'b1;
			else if (i_done)
				r_issued <= 1'b0;
			r_count <= (w_delay_len == '0 || w_delay_end) ? '0 : r_count + 1'b1;
			case (r_state)
				ST_RESET_HOLD:
				begin
					r_state    <= w_delay_end ? ST_RESET_WAIT : r_state;
					r_nreset   <= w_delay_end;     // Release with clock running
					r_clock_en <= w_delay_end;
				end
				ST_RESET_WAIT:   r_state <= w_delay_end ? ST_RD_CONFIG : r_state;
				ST_RD_CONFIG:    r_state <= w_step ? ST_WR_ROW_MSB : r_state;
				ST_WR_ROW_MSB:   r_state <= w_step ? ST_WR_ROW_LSB : r_state;
				ST_WR_ROW_LSB:   r_state <= w_step ? ST_CMD_START : r_state;
				ST_CMD_START:    r_state <= w_step ? ST_CMD_CURRENT : r_state;
				ST_CMD_CURRENT:  r_state <= w_step ? ST_RD_START_MSB : r_state;
				ST_RD_START_MSB: r_state <= w_step ? ST_RD_START_LSB : r_state;
				ST_RD_START_LSB: r_state <= w_step ? ST_WR_CLOCK : r_state;
				ST_WR_CLOCK:     r_state <= w_step ? ST_RD_CLOCK : r_state;
				ST_RD_CLOCK:
				begin
					r_state <= w_step ? ST_WR_STANDBY : r_state;
					if (w_step)
						r_fail <= 1'b0;                // All checks passed
				end
				ST_WR_STANDBY:
				begin
					r_state <= w_step ? ST_STANDBY_WAIT : r_state;
					r_ready <= w_step;
				end
				ST_RETRY_WAIT:   r_state <= w_delay_end ? ST_RD_CONFIG : r_state;
				ST_STANDBY_WAIT: r_state <= w_delay_end ? ST_WR_NORMAL : r_state;
				ST_WR_NORMAL:
				begin
					r_state <= w_step ? ST_NORMAL : r_state;
					r_run   <= w_step;                 // Frames start with normal mode
				end
				ST_NORMAL:
				begin
					r_state <= i_shutdown_n ? r_state : ST_WR_SLEEP;
					r_run   <= i_shutdown_n;           // Stop frames before sleep write
				end
				ST_WR_SLEEP:     r_state <= w_step ? ST_SLEEP_WAIT : r_state;
				ST_SLEEP_WAIT:
				begin
					r_state    <= w_delay_end ? ST_SHUTDOWN : r_state;
					r_nreset   <= !w_delay_end;
					r_clock_en <= !w_delay_end;
					r_ready    <= !w_delay_end;
				end
				default:         r_state <= ST_SHUTDOWN; // Parked until reset
			endcase
			if (w_retry)
			begin
				r_state <= ST_RETRY_WAIT;              // Bad read back
				r_fail  <= 1'b1;
			end
		end
	end

	// Transaction payload, loaded with the start strobe
	always_ff @(posedge i_clock)
	begin
		if (w_issue)
			{r_tx_read, r_tx_addr, r_tx_wdata} <= w_tx;
	end

	assign o_tx_start = r_tx_start;
	assign o_tx_read  = r_tx_read;
	assign o_tx_addr  = r_tx_addr;
	assign o_tx_wdata = r_tx_wdata;
	assign o_nreset   = r_nreset;
	assign o_clock_en = r_clock_en;
	assign o_run      = r_run;
	assign o_ready    = r_ready;
	assign o_fail     = r_fail;

endmodule

//--- hw/lcd_frame_gen.sv
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module lcd_frame_gen
(
	input  logic               i_clock,
	input  logic               i_rst,
	input  logic               i_run,     // Counters held clear while low
	output lcd_pkg::lcd_word_t o_data,
	output logic               o_valid,
	output logic               o_update
);

	import lcd_pkg::*;

	localparam lcd_count_t DATA_END  = `LCD_LINES * `LCD_WORDS_LINE;  // Start of back porch
	localparam lcd_count_t FRAME_LEN = DATA_END + `LCD_BACK_PORCH;

	lcd_count_t r_pos;      // Cycle within frame
	lcd_count_t r_word;     // Word within line
	lcd_count_t r_line;
	logic       r_first;    // No update in first frame
	logic       r_valid;
	logic       r_update;
	lcd_word_t  r_data;
	logic       w_in_data;  // Word carries pixels
	logic       w_band;     // Line outside the dark band

	assign w_in_data = (r_pos < DATA_END) && (r_word < `LCD_WORDS_DATA);
	assign w_band    = (r_line < `LCD_BAND_LO) || (r_line > `LCD_BAND_HI);

	//////////////////////////////////////////////////////////////////////
	// Frame counters and registered strobes
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clock)
	begin
		if (i_rst || !i_run)
		begin
			r_pos    <= '0;
			r_word   <= '0;
			r_line   <= '0;
			r_first  <= 1'b1;
			r_valid  <= 1'b0;
			r_update <= 1'b0;
		end
		else
		begin
			r_valid  <= w_in_data;
			r_update <= !r_first && (r_pos < `LCD_UPDATE_LEN);
			if (r_pos == FRAME_LEN - 1)
			begin
				r_pos   <= '0;                 // Wrap after back porch
				r_word  <= '0;
				r_line  <= '0;
				r_first <= 1'b0;
			end
			else
			begin
				r_pos <= r_pos + 1'b1;
				if (r_pos < DATA_END)
				begin
					if (r_word == `LCD_WORDS_LINE - 1)
					begin
						r_word <= '0;
						r_line <= r_line + 1'b1;
					end
					else
						r_word <= r_word + 1'b1;
				end
			end
		end
	end

	// Band test pattern
	always_ff @(posedge i_clock)
	begin
		r_data <= (i_run && w_in_data && w_band) ? '1 : '0;
	end

	assign o_data   = r_data;
	assign o_valid  = r_valid;
	assign o_update = r_update;

endmodule

//--- hw/lcd_top.sv
`timescale 1ns/1ps

module lcd_top
(
	input  logic               i_clock,
	input  logic               i_rst,
	input  logic               i_shutdown_n,  // Low requests shutdown
	input  logic               i_lcd_miso,
	output logic               o_lcd_clock,   // Gated panel clock
	output logic               o_nreset,
	output lcd_pkg::lcd_word_t o_data,
	output logic               o_valid,
	output logic               o_update,
	output logic               o_lcd_sclk,
	output logic               o_lcd_mosi,
	output logic               o_lcd_sen,
	output logic               o_ready,
	output logic               o_fail
);

	import lcd_pkg::*;

	logic      w_tx_start;
	logic      w_tx_read;
	lcd_addr_t w_tx_addr;
	lcd_byte_t w_tx_wdata;
	lcd_byte_t w_rdata;
	logic      w_busy;
	logic      w_done;
	logic      w_clock_en;
	logic      w_run;
	logic      r_gate_en;   // Enable moved to the low clock phase

	// Change the gate only while the clock is low
	always_ff @(negedge i_clock)
	begin
		if (i_rst)
			r_gate_en <= 1'b0;
		else
			r_gate_en <= w_clock_en;
	end

	assign o_lcd_clock = i_clock & r_gate_en;

	lcd_power_seq u_seq (
		.i_clock      (i_clock),
		.i_rst        (i_rst),
		.i_shutdown_n (i_shutdown_n),
		.i_busy       (w_busy),
		.i_done       (w_done),
		.i_rdata      (w_rdata),
		.o_tx_start   (w_tx_start),
		.o_tx_read    (w_tx_read),
		.o_tx_addr    (w_tx_addr),
		.o_tx_wdata   (w_tx_wdata),
		.o_nreset     (o_nreset),
		.o_clock_en   (w_clock_en),
		.o_run        (w_run),
		.o_ready      (o_ready),
		.o_fail       (o_fail)
	);

	lcd_serial_tcvr u_tcvr (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.i_start (w_tx_start),
		.i_read  (w_tx_read),
		.i_addr  (w_tx_addr),
		.i_wdata (w_tx_wdata),
		.i_miso  (i_lcd_miso),
		.o_sclk  (o_lcd_sclk),
		.o_mosi  (o_lcd_mosi),
		.o_sen   (o_lcd_sen),
		.o_busy  (w_busy),
		.o_done  (w_done),
		.o_rdata (w_rdata)
	);

	lcd_frame_gen u_frame (
		.i_clock  (i_clock),
		.i_rst    (i_rst),
		.i_run    (w_run),
		.o_data   (o_data),
		.o_valid  (o_valid),
		.o_update (o_update)
	);

endmodule

//--- sim/lcd_panel_model.sv
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module lcd_panel_model
(
	input  logic       i_sclk,
	input  logic       i_sen,
	input  logic       i_mosi,
	input  int         i_bad_reads,  // Config reads answered wrongly
	output logic       o_miso,
	output int         o_wr_cnt,     // Writes logged so far
	output logic [6:0] o_wr_addr,    // Last write
	output logic [7:0] o_wr_data,
	output int         o_cfg_cnt     // Config reads answered so far
);

	logic [7:0]  regs [0:127];       // Panel register file
	logic [15:0] r_frame  = '0;      // Received bits, newest in LSB
	logic [7:0]  r_reply  = '0;      // Read data for this frame
	logic        r_miso   = 1'b0;
	int          r_bits   = 0;       // Rising sclk edges in this frame
	int          r_wr_cnt = 0;
	int          r_cfg_cnt = 0;
	logic [6:0]  r_wr_addr = '0;
	logic [7:0]  r_wr_data = '0;

	initial
	begin
		for (int k = 0; k < 128; k++)
			regs[k] = 8'(k * 3) ^ 8'hA5;      // Start pointers nonzero until set
	end

	//////////////////////////////////////////////////////////////////////
	// Receive side, mosi taken on rising sclk
	//////////////////////////////////////////////////////////////////////
	always @(posedge i_sen or posedge i_sclk)
	begin
		if (!i_sclk)
			r_bits = 0;                       // Sen rose, new frame
		else
		begin
			r_frame = {r_frame[14:0], i_mosi};
			r_bits  = r_bits + 1;
			if (r_bits == 16 && !r_frame[15])
			begin
				regs[r_frame[14:8]] = r_frame[7:0];
				if (r_frame[14:8] == `REG_CMD && r_frame[7:0] == `CMD_SET_START)
				begin
					regs[`REG_START_BASE]         = regs[`REG_ROW_BASE];
					regs[`REG_START_BASE + 7'd1]  = regs[`REG_ROW_BASE + 7'd1];
				end
				r_wr_addr = r_frame[14:8];    // Log the pair
				r_wr_data = r_frame[7:0];
				r_wr_cnt  = r_wr_cnt + 1;
			end
		end
	end

	// Reply side, miso changes after falling sclk
	always @(negedge i_sclk)
	begin
		if (i_sen && r_bits == 8 && r_frame[7])
		begin
			if (r_frame[6:0] == `REG_CONFIG)
			begin
				r_reply   = (r_cfg_cnt < i_bad_reads) ? ~`CONFIG_ID : `CONFIG_ID;
				r_cfg_cnt = r_cfg_cnt + 1;
			end
			else
				r_reply = regs[r_frame[6:0]];
		end
		r_miso = (r_bits >= 8 && r_bits < 16) ? r_reply[15 - r_bits] : 1'b0;
	end

	assign o_miso    = r_miso;
	assign o_wr_cnt  = r_wr_cnt;
	assign o_wr_addr = r_wr_addr;
	assign o_wr_data = r_wr_data;
	assign o_cfg_cnt = r_cfg_cnt;

endmodule

//--- sim/lcd_asserts.sv
`timescale 1ns/1ps

module lcd_asserts
(
	input logic i_clock,
	input logic i_rst,
	input logic i_start,
	input logic i_busy,
	input logic i_done,
	input logic i_run,
	input logic i_nreset
);

	// Start only toward an idle transceiver
	start_idle: assert property (@(posedge i_clock) disable iff (i_rst)
		i_start |-> !i_busy)
		else $error("start issued while the transceiver is busy");

	done_pulse: assert property (@(posedge i_clock) disable iff (i_rst)
		i_done |=> !i_done)                   // Single cycle strobe
		else $error("done held high for more than one cycle");

	run_in_reset: assert property (@(posedge i_clock) disable iff (i_rst)
		i_run |-> i_nreset)
		else $error("frames running while the panel is in reset");

endmodule

bind lcd_serial_tcvr lcd_asserts u_tcvr_asserts (
	.i_clock  (i_clock),
	.i_rst    (i_rst),
	.i_start  (i_start),
	.i_busy   (o_busy),
	.i_done   (o_done),
	.i_run    (1'b0),
	.i_nreset (1'b1)
);

bind lcd_power_seq lcd_asserts u_seq_asserts (
	.i_clock  (i_clock),
	.i_rst    (i_rst),
	.i_start  (o_tx_start),
	.i_busy   (i_busy),
	.i_done   (i_done),
	.i_run    (o_run),
	.i_nreset (o_nreset)
);

//--- sim/lcd_tb.sv
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module lcd_tb;

	localparam int DATA_END   = `LCD_LINES * `LCD_WORDS_LINE;
	localparam int FRAME_LEN  = DATA_END + `LCD_BACK_PORCH;
	localparam int TX_CYCLES  = 32 * `LCD_SCLK_HALF + 4;   // Transaction plus handoff
	localparam int RUN_CYCLES = 4 + `LCD_RESET_HOLD + `LCD_RESET_WAIT
		+ 2 * (`LCD_RETRY_WAIT + TX_CYCLES) + 14 * TX_CYCLES
		+ `LCD_STANDBY_WAIT + 4 * FRAME_LEN + `LCD_SLEEP_WAIT + 40;
	localparam int LIMIT_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;

	logic        clock = 1'b0;
	logic        rst;
	logic        shutdown_n;
	logic        miso;
	logic        lcd_clock, nreset, valid, update, sclk, mosi, sen, ready, fail;
	logic [31:0] data;
	int          wr_cnt, cfg_cnt;
	logic [6:0]  wr_addr;
	logic [7:0]  wr_data;

	int          seed;
	int          bad_reads;        // Wrong config answers, 0 to 2
	int          shutdown_frames;  // Frames before shutdown, 1 to 3
	logic [14:0] exp_writes [$];   // Address and data, in order
	int          wr_seen = 0, cfg_seen = 0, hold_cnt = 0;
	int          frame_pos = 0, frame_idx = 0, frame_words = 0, frames_done = 0;
	bit          nreset_seen = 0, retry_pending = 0, fail_seen = 0, ready_seen = 0;
	bit          stream_started = 0, shutdown_req = 0, sleep_logged = 0, nreset_down = 0;

	always #4 clock = ~clock;

	lcd_top u_lcd_top (
		.i_clock (clock), .i_rst (rst), .i_shutdown_n (shutdown_n), .i_lcd_miso (miso),
		.o_lcd_clock (lcd_clock), .o_nreset (nreset), .o_data (data), .o_valid (valid),
		.o_update (update), .o_lcd_sclk (sclk), .o_lcd_mosi (mosi), .o_lcd_sen (sen),
		.o_ready (ready), .o_fail (fail)
	);

	lcd_panel_model u_panel (
		.i_sclk (sclk), .i_sen (sen), .i_mosi (mosi), .i_bad_reads (bad_reads),
		.o_miso (miso), .o_wr_cnt (wr_cnt), .o_wr_addr (wr_addr), .o_wr_data (wr_data),
		.o_cfg_cnt (cfg_cnt)
	);

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			report_error($sformatf("Fail at %0t: %s expected %h got %h",
				$time, name, expected, actual));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitor, sampled mid high phase where everything has settled
	//////////////////////////////////////////////////////////////////////
	always
	begin
		logic [14:0] exp_wr;
		logic [31:0] exp_data;
		int          line_idx;
		@(posedge clock);
		#2;
		if (!nreset_seen && !rst)
		begin
			check_value("o_lcd_clock", 0, lcd_clock);
			check_value("o_valid", 0, valid);
			check_value("o_update", 0, update);
			check_value("o_ready", 0, ready);
			if (nreset === 1'b1)
			begin
				if (hold_cnt < `LCD_RESET_HOLD)
					report_error($sformatf("o_nreset released after %0d cycles", hold_cnt));
				nreset_seen = 1;
			end
			else
				hold_cnt++;
		end
		if (cfg_cnt != cfg_seen)
		begin
			if (retry_pending)
				check_value("o_fail", 1, fail_seen);  // Seen before the retry
			retry_pending = (cfg_seen < bad_reads);
			fail_seen     = 0;
			cfg_seen++;
		end
		if (retry_pending && fail)
			fail_seen = 1;
		if (wr_cnt != wr_seen)
		begin
			wr_seen++;
			if (retry_pending)
				report_error("register write logged before the config read was retried");
			else if (exp_writes.size() == 0)
				report_error("register write logged after the sleep write");
			else
			begin
				exp_wr = exp_writes.pop_front();
				check_value("write address", exp_wr[14:8], wr_addr);
				check_value("write data", exp_wr[7:0], wr_data);
				if (exp_writes.size() == 0)
				begin
					if (!shutdown_req)
						report_error("sleep mode written without a shutdown request");
					sleep_logged = 1;
				end
			end
		end
		if (ready && !ready_seen)
		begin
			ready_seen = 1;
			check_value("o_fail", 0, fail);
			check_value("config reads", bad_reads + 1, cfg_seen);
			check_value("writes at o_ready", 6, wr_seen);
		end
		// Frame stream model
		if (nreset_seen && !shutdown_req)
		begin
			if (!stream_started && valid)
				stream_started = 1;          // Frame 0 starts with first valid
			if (stream_started)
			begin
				if (frame_pos == FRAME_LEN)
				begin
					check_value("valid words per frame",
						`LCD_LINES * `LCD_WORDS_DATA, frame_words);
					frame_pos   = 0;
					frame_words = 0;
					frame_idx++;
					frames_done++;
				end
				check_value("o_valid", (frame_pos < DATA_END)
					&& (frame_pos % `LCD_WORDS_LINE < `LCD_WORDS_DATA), valid);
				check_value("o_update", (frame_idx > 0)
					&& (frame_pos < `LCD_UPDATE_LEN), update);
				if (valid)
				begin
					line_idx = frame_words / `LCD_WORDS_DATA;
					exp_data = (line_idx < `LCD_BAND_LO || line_idx > `LCD_BAND_HI)
						? 32'hFFFF_FFFF : 32'h0;
					check_value("o_data", exp_data, data);
					frame_words++;
				end
				frame_pos++;
			end
			else
				check_value("o_update", 0, update);
		end
		if (sleep_logged)
		begin
			check_value("o_valid", 0, valid);
			check_value("o_update", 0, update);
		end
		if (nreset_down)
		begin
			check_value("o_nreset", 0, nreset);
			check_value("o_lcd_clock", 0, lcd_clock);  // Gate closed a half cycle later
			check_value("o_ready", 0, ready);
		end
		else if (sleep_logged && nreset === 1'b0)
			nreset_down = 1;
	end

	initial
	begin
		#(LIMIT_CYCLES * 8);
		report_error("Timeout: the shutdown sequence did not finish in time");
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		rst             = 1'b1;
		shutdown_n      = 1'b1;
		seed            = 32'h26c4;
		bad_reads       = $unsigned($random(seed)) % 3;
		shutdown_frames = 1 + $unsigned($random(seed)) % 3;
		exp_writes.push_back({`REG_ROW_BASE, 8'h00});
		exp_writes.push_back({`REG_ROW_BASE + 7'd1, 8'h00});
		exp_writes.push_back({`REG_CMD, `CMD_SET_START});
		exp_writes.push_back({`REG_CMD, `CMD_SET_CURRENT});
		exp_writes.push_back({`REG_CLOCK, 8'(`LCD_CLOCK_MHZ)});
		exp_writes.push_back({`REG_MODE, `MODE_STANDBY});
		exp_writes.push_back({`REG_MODE, `MODE_NORMAL});
		exp_writes.push_back({`REG_MODE, `MODE_SLEEP});
		repeat (4) @(posedge clock);
		#1 rst = 1'b0;
		wait (frames_done >= shutdown_frames);
		@(posedge clock);
		#1;
		shutdown_n   = 1'b0;                 // Request sleep
		shutdown_req = 1;
		wait (nreset_down);
		repeat (40) @(posedge clock);        // Panel stays down, monitor keeps checking
		#3;
		$display("Verification passed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+hw
hw/lcd_pkg.sv
hw/lcd_serial_tcvr.sv
hw/lcd_power_seq.sv
hw/lcd_frame_gen.sv
hw/lcd_top.sv
sim/lcd_panel_model.sv
sim/lcd_asserts.sv
sim/lcd_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = lcd_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log
SOURCES  = $(wildcard hw/*.sv hw/*.svh sim/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
